/* src/mem_bus_pkg.sv */
package mem_bus_pkg;

	// address and data widths on the memory side.
	localparam int ADDR_WIDTH   = 32;
	localparam int DATA_WIDTH   = 64;

	// request id width, one id per outstanding tid.
	localparam int MEM_ID_WIDTH = 4;

	// read request towards the memory expander.
	typedef struct packed {
		logic [ADDR_WIDTH-1:0]   addr;
		logic [MEM_ID_WIDTH-1:0] id;
	} mem_req_t;

	// read data coming back, in request order.
	typedef struct packed {
		logic [DATA_WIDTH-1:0]   data;
		logic [MEM_ID_WIDTH-1:0] id; // carried along, not matched.
	} mem_rsp_t;

	// line fill offered to the cache arrays.
	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] data;
	} fill_t;

endpackage

/* src/miss_track_pkg.sv */
package miss_track_pkg;

	// transaction ids, handed out in arrival order.
	localparam int TID_WIDTH      = 4;
	localparam int NUM_TIDS       = 16;

	// outstanding misses waiting for memory.
	localparam int MISS_DEPTH     = 8;
	localparam int MISS_PTR_WIDTH = $clog2(MISS_DEPTH);

	// request from the core, hit data valid only when hit is set.
	typedef struct packed {
		logic                              hit;
		logic [mem_bus_pkg::ADDR_WIDTH-1:0] addr;
		logic [mem_bus_pkg::DATA_WIDTH-1:0] data;
	} core_req_t;

	// data returned to the core, tagged with its tid.
	typedef struct packed {
		logic [TID_WIDTH-1:0]               tid;
		logic [mem_bus_pkg::DATA_WIDTH-1:0] data;
	} core_rsp_t;

	// one outstanding miss.
	typedef struct packed {
		logic [mem_bus_pkg::ADDR_WIDTH-1:0] addr;
		logic [TID_WIDTH-1:0]               tid;
	} miss_entry_t;

	// write into the reorder buffer.
	typedef struct packed {
		logic [TID_WIDTH-1:0]               tid;
		logic [mem_bus_pkg::DATA_WIDTH-1:0] data;
	} rob_entry_t;

endpackage

/* src/tid_counter.sv */
`timescale 1ns/10ps

module tid_counter (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 alloc_i,
	input  logic                                 retire_i,
	output logic [miss_track_pkg::TID_WIDTH-1:0] alloc_tid_o,
	output logic [miss_track_pkg::TID_WIDTH-1:0] head_tid_o,
	output logic                                 full_o
);
	import miss_track_pkg::*;

	logic [TID_WIDTH-1:0] alloc_ptr;
	logic [TID_WIDTH-1:0] retire_ptr;
	logic [TID_WIDTH:0]   count;

	// both pointers wrap at NUM_TIDS.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			alloc_ptr  <= '0;
			retire_ptr <= '0;
			count      <= '0;
		end else begin
			if (alloc_i) begin
				alloc_ptr <= alloc_ptr + 1'b1;
			end
			if (retire_i) begin
				retire_ptr <= retire_ptr + 1'b1;
			end
			case ({alloc_i, retire_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // none or both.
			endcase
		end
	end

	assign alloc_tid_o = alloc_ptr;
	assign head_tid_o  = retire_ptr; // oldest tid still in flight.
	assign full_o      = (count == (TID_WIDTH+1)'(NUM_TIDS));

	// the reorder buffer only retires tids that were handed out.
	a_no_retire_when_idle: assert property (
		@(posedge clk) disable iff (!rst_n)
		retire_i |-> (count != '0)
	);

endmodule

/* src/miss_fifo.sv */
`timescale 1ns/10ps

module miss_fifo (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        push_i,
	input  miss_track_pkg::miss_entry_t push_entry_i,
	input  logic                        pop_i,
	output miss_track_pkg::miss_entry_t head_o,
	output logic                        empty_o,
	output logic                        full_o
);
	import mem_bus_pkg::*;
	import miss_track_pkg::*;

	logic [ADDR_WIDTH-1:0]     addr_mem [MISS_DEPTH];
	logic [TID_WIDTH-1:0]      tid_mem  [MISS_DEPTH];
	logic [MISS_PTR_WIDTH-1:0] head_ptr;
	logic [MISS_PTR_WIDTH-1:0] tail_ptr;
	logic [MISS_PTR_WIDTH:0]   count;

	assign tail_ptr = head_ptr + count[MISS_PTR_WIDTH-1:0]; // wraps at MISS_DEPTH.

	always_ff @(posedge clk) begin
		if (push_i) begin
			addr_mem[tail_ptr] <= push_entry_i.addr;
			tid_mem[tail_ptr]  <= push_entry_i.tid;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head_ptr <= '0;
			count    <= '0;
		end else begin
			if (pop_i) begin
				head_ptr <= head_ptr + 1'b1;
			end
			case ({push_i, pop_i})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head_o.addr = addr_mem[head_ptr];
	assign head_o.tid  = tid_mem[head_ptr];
	assign empty_o     = (count == '0);
	assign full_o      = (count == (MISS_PTR_WIDTH+1)'(MISS_DEPTH));

	// top level holds off requests while full.
	a_no_push_full: assert property (
		@(posedge clk) disable iff (!rst_n)
		push_i |-> !full_o
	);

	// handler pops only against a live entry.
	a_no_pop_empty: assert property (
		@(posedge clk) disable iff (!rst_n)
		pop_i |-> !empty_o
	);

endmodule

/* src/read_miss_handler.sv */
`timescale 1ns/10ps

module read_miss_handler (
	input  logic                        clk,
	input  logic                        rst_n,

	input  logic                        mem_rsp_valid_i,
	output logic                        mem_rsp_ready_o,
	input  mem_bus_pkg::mem_rsp_t       mem_rsp_i,

	output logic                        pop_o,
	input  logic                        empty_i,
	input  miss_track_pkg::miss_entry_t head_i,

	output logic                        rob_wr_o,
	input  logic                        busy_i,
	output miss_track_pkg::rob_entry_t  rob_entry_o,

	output logic                        fill_valid_o,
	input  logic                        fill_ready_i,
	output mem_bus_pkg::fill_t          fill_o
);
	import mem_bus_pkg::*;
	import miss_track_pkg::*;

	typedef enum logic {
		S_IDLE,
		S_RUN
	} state_t;

	state_t     state;
	state_t     state_n;
	logic       take;
	logic       done;
	fill_t      fill_q;
	rob_entry_t rob_q;

	// responses arrive in request order, so the fifo head is the match.
	assign take = (state == S_IDLE) && mem_rsp_valid_i && !empty_i;
	assign done = (state == S_RUN) && fill_ready_i && !busy_i; // hits win the rob port.

	always_comb begin
		state_n = state;
		case (state)
			S_IDLE:  if (take) state_n = S_RUN;
			S_RUN:   if (done) state_n = S_IDLE;
			default: state_n = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			state <= state_n;
		end
	end

	// held steady for the whole of the run state.
	always_ff @(posedge clk) begin
		if (take) begin
			fill_q.addr <= head_i.addr;
			fill_q.data <= mem_rsp_i.data;
			rob_q.tid   <= head_i.tid;
			rob_q.data  <= mem_rsp_i.data;
		end
	end

	assign mem_rsp_ready_o = (state == S_IDLE);
	assign pop_o           = take;
	assign fill_valid_o    = (state == S_RUN);
	assign fill_o          = fill_q;
	assign rob_wr_o        = done; // rob write lands with the fill.
	assign rob_entry_o     = rob_q;

	// memory never answers a request that was not issued.
	a_rsp_needs_miss: assert property (
		@(posedge clk) disable iff (!rst_n)
		mem_rsp_valid_i |-> !empty_i
	);

endmodule

/* src/reorder_buffer.sv */
`timescale 1ns/10ps

module reorder_buffer (
	input  logic                                 clk,
	input  logic                                 rst_n,

	input  logic                                 hit_wr_i,
	input  miss_track_pkg::rob_entry_t           hit_entry_i,

	input  logic                                 miss_wr_i,
	input  miss_track_pkg::rob_entry_t           miss_entry_i,
	output logic                                 busy_o,

	input  logic [miss_track_pkg::TID_WIDTH-1:0] head_tid_i,

	output logic                                 rsp_valid_o,
	input  logic                                 rsp_ready_i,
	output miss_track_pkg::core_rsp_t            rsp_o,

	output logic                                 retire_o
);
	import mem_bus_pkg::*;
	import miss_track_pkg::*;

	logic [DATA_WIDTH-1:0] data_mem [NUM_TIDS];
	logic [NUM_TIDS-1:0]   slot_valid;
	logic                  wr_en;
	rob_entry_t            wr_entry;

	// one write port, hit side first.
	always_comb begin
		wr_en    = 1'b0;
		wr_entry = miss_entry_i;
		if (hit_wr_i) begin
			wr_en    = 1'b1;
			wr_entry = hit_entry_i;
		end else if (miss_wr_i) begin
			wr_en = 1'b1;
		end
	end

	assign busy_o = hit_wr_i; // miss write has to wait this cycle.

	always_ff @(posedge clk) begin
		if (wr_en) begin
			data_mem[wr_entry.tid] <= wr_entry.data;
		end
	end

	// written slot and retired slot are never the same one.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot_valid <= '0;
		end else begin
			if (wr_en) begin
				slot_valid[wr_entry.tid] <= 1'b1;
			end
			if (retire_o) begin
				slot_valid[head_tid_i] <= 1'b0;
			end
		end
	end

	// only the oldest tid may leave.
	assign rsp_valid_o = slot_valid[head_tid_i];
	assign rsp_o.tid   = head_tid_i;
	assign rsp_o.data  = data_mem[head_tid_i];
	assign retire_o    = rsp_valid_o && rsp_ready_i;

	// tid allocation must not hand out a slot still waiting to retire.
	a_no_overwrite: assert property (
		@(posedge clk) disable iff (!rst_n)
		wr_en |-> !slot_valid[wr_entry.tid]
	);

endmodule

/* src/miss_path_top.sv */
`timescale 1ns/10ps

module miss_path_top (
	input  logic                      clk,
	input  logic                      rst_n,

	input  logic                      req_valid_i,
	output logic                      req_ready_o,
	input  miss_track_pkg::core_req_t req_i,

	output logic                      mem_req_valid_o,
	output mem_bus_pkg::mem_req_t     mem_req_o,

	input  logic                      mem_rsp_valid_i,
	output logic                      mem_rsp_ready_o,
	input  mem_bus_pkg::mem_rsp_t     mem_rsp_i,

	output logic                      fill_valid_o,
	input  logic                      fill_ready_i,
	output mem_bus_pkg::fill_t        fill_o,

	output logic                      rsp_valid_o,
	input  logic                      rsp_ready_i,
	output miss_track_pkg::core_rsp_t rsp_o
);
	import mem_bus_pkg::*;
	import miss_track_pkg::*;

	logic                 accept;
	logic                 hit_wr;
	logic                 miss_push;
	logic                 tid_full;
	logic                 fifo_full;
	logic                 fifo_empty;
	logic                 fifo_pop;
	logic                 retire;
	logic                 rob_wr;
	logic                 rob_busy;
	logic [TID_WIDTH-1:0] alloc_tid;
	logic [TID_WIDTH-1:0] head_tid;
	miss_entry_t          push_entry;
	miss_entry_t          fifo_head;
	rob_entry_t           hit_entry;
	rob_entry_t           miss_rob_entry;

	// hits and misses both stall on a full tid counter or a full fifo.
	assign req_ready_o = !tid_full && !fifo_full;
	assign accept      = req_valid_i && req_ready_o;
	assign hit_wr      = accept && req_i.hit;
	assign miss_push   = accept && !req_i.hit;

	assign hit_entry.tid    = alloc_tid;
	assign hit_entry.data   = req_i.data;
	assign push_entry.addr  = req_i.addr;
	assign push_entry.tid   = alloc_tid;

	assign mem_req_valid_o  = miss_push; // single-cycle strobe with no back-pressure.
	assign mem_req_o.addr   = req_i.addr;
	assign mem_req_o.id     = alloc_tid;

	tid_counter i_tid_counter (
		.clk         (clk),
		.rst_n       (rst_n),
		.alloc_i     (accept),
		.retire_i    (retire),
		.alloc_tid_o (alloc_tid),
		.head_tid_o  (head_tid),
		.full_o      (tid_full)
	);

	miss_fifo i_miss_fifo (
		.clk          (clk),
		.rst_n        (rst_n),
		.push_i       (miss_push),
		.push_entry_i (push_entry),
		.pop_i        (fifo_pop),
		.head_o       (fifo_head),
		.empty_o      (fifo_empty),
		.full_o       (fifo_full)
	);

	read_miss_handler i_read_miss_handler (
		.clk             (clk),
		.rst_n           (rst_n),
		.mem_rsp_valid_i (mem_rsp_valid_i),
		.mem_rsp_ready_o (mem_rsp_ready_o),
		.mem_rsp_i       (mem_rsp_i),
		.pop_o           (fifo_pop),
		.empty_i         (fifo_empty),
		.head_i          (fifo_head),
		.rob_wr_o        (rob_wr),
		.busy_i          (rob_busy),
		.rob_entry_o     (miss_rob_entry),
		.fill_valid_o    (fill_valid_o),
		.fill_ready_i    (fill_ready_i),
		.fill_o          (fill_o)
	);

	reorder_buffer i_reorder_buffer (
		.clk          (clk),
		.rst_n        (rst_n),
		.hit_wr_i     (hit_wr),
		.hit_entry_i  (hit_entry),
		.miss_wr_i    (rob_wr),
		.miss_entry_i (miss_rob_entry),
		.busy_o       (rob_busy),
		.head_tid_i   (head_tid),
		.rsp_valid_o  (rsp_valid_o),
		.rsp_ready_i  (rsp_ready_i),
		.rsp_o        (rsp_o),
		.retire_o     (retire)
	);

endmodule

/* verif/miss_path_tb.sv */
`timescale 1ns/10ps

module miss_path_tb;
	import mem_bus_pkg::*;
	import miss_track_pkg::*;

	localparam int    MAX_TESTS = 64;
	localparam string TEST_FILE = "verif/miss_path_tests.txt";

	logic      clk;
	logic      rst_n;
	logic      req_valid_i;
	logic      req_ready_o;
	core_req_t req_i;
	logic      mem_req_valid_o;
	mem_req_t  mem_req_o;
	logic      mem_rsp_valid_i;
	logic      mem_rsp_ready_o;
	mem_rsp_t  mem_rsp_i;
	logic      fill_valid_o;
	logic      fill_ready_i;
	fill_t     fill_o;
	logic      rsp_valid_o;
	logic      rsp_ready_i;
	core_rsp_t rsp_o;

	string                 names     [MAX_TESTS];
	logic                  hits      [MAX_TESTS];
	logic [ADDR_WIDTH-1:0] addrs     [MAX_TESTS];
	logic [DATA_WIDTH-1:0] datas     [MAX_TESTS];
	int                    delays    [MAX_TESTS];
	int                    miss_line [MAX_TESTS]; // test index of each miss in miss order.
	int                    req_cycle [MAX_TESTS];

	int n_tests = 0, n_misses = 0, max_delay = 0, limit = 0, cycle = 0;
	int acc_count = 0, miss_acc = 0, mem_taken = 0, req_seen = 0;
	int fill_count = 0, rsp_count = 0, collisions = 0;
	int value_errors = 0, other_errors = 0;
	bit loaded = 1'b0, running = 1'b0, saw_full = 1'b0;

	miss_path_top i_miss_path_top (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	task automatic report_mismatch(string test, string what, logic [63:0] expected,
			logic [63:0] actual);
		value_errors++;
		$display("FAILED %s %s: expected %h, actual %h", test, what, expected, actual);
	endtask

	task automatic report_problem(string what);
		other_errors++;
		$display("ERROR %s", what);
	endtask

	task automatic print_counts();
		$display("value errors %0d, other errors %0d, responses %0d of %0d, fills %0d of %0d",
			value_errors, other_errors, rsp_count, n_tests, fill_count, n_misses);
	endtask

	task automatic read_tests();
		int                    fd;
		int                    hit_v;
		int                    dly;
		string                 line;
		string                 name;
		logic [ADDR_WIDTH-1:0] addr_v;
		logic [DATA_WIDTH-1:0] data_v;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) begin
			report_problem("could not open the test file");
			return;
		end
		while (!$feof(fd) && n_tests < MAX_TESTS) begin
			line = "";
			if ($fgets(line, fd) == 0 || line.len() < 2 || line.getc(0) == "#") continue;
			if ($sscanf(line, "%s %d %h %h %d", name, hit_v, addr_v, data_v, dly) != 5) continue;
			names[n_tests]  = name;
			hits[n_tests]   = (hit_v != 0);
			addrs[n_tests]  = addr_v;
			datas[n_tests]  = data_v;
			delays[n_tests] = dly;
			if (hit_v == 0) begin
				miss_line[n_misses] = n_tests;
				n_misses++;
			end
			if (dly > max_delay) max_delay = dly;
			n_tests++;
		end
		$fclose(fd);
	endtask

	task automatic drive_requests();
		bit taken;
		for (int i = 0; i < n_tests; i++) begin
			req_valid_i = 1'b1;
			req_i.hit   = hits[i];
			req_i.addr  = addrs[i];
			req_i.data  = hits[i] ? datas[i] : '0; // miss data has to come from memory.
			do begin
				@(negedge clk);
				taken = req_ready_o;
				@(posedge clk);
				#2;
			end while (!taken);
		end
		req_valid_i = 1'b0;
		req_i       = '0;
	endtask

	// answers in request order after each line's delay.
	task automatic serve_memory();
		int line;
		bit taken;
		for (int k = 0; k < n_misses; k++) begin
			line = miss_line[k];
			while (req_seen <= k || cycle < req_cycle[k] + 1 + delays[line]) begin
				@(posedge clk);
				#2;
			end
			mem_rsp_valid_i = 1'b1;
			mem_rsp_i.data  = datas[line];
			mem_rsp_i.id    = MEM_ID_WIDTH'(line);
			do begin
				@(negedge clk);
				taken = mem_rsp_ready_o;
				@(posedge clk);
				#2;
			end while (!taken);
			mem_rsp_valid_i = 1'b0;
		end
	endtask

	initial begin
		while (!running) @(posedge clk);
		#2;
		serve_memory();
	end

	initial begin
		void'($urandom(32'h9b9ed0c0));
		while (!running) @(posedge clk);
		forever begin
			@(posedge clk);
			#2;
			fill_ready_i = ($urandom % 4) != 0;
			rsp_ready_i  = saw_full && (($urandom % 3) != 0); // held off until all tids are taken.
		end
	end

	// handshake monitor and output checks.
	always @(negedge clk) begin
		int line;
		bit acc;
		bit hit_wr;
		bit exp_ready;
		if (running) begin
			acc       = req_valid_i && req_ready_o;
			hit_wr    = acc && req_i.hit;
			line      = (acc_count < n_tests) ? acc_count : n_tests - 1;
			exp_ready = (acc_count - rsp_count < NUM_TIDS) &&
				(miss_acc - mem_taken < MISS_DEPTH);
			assert (req_ready_o == exp_ready)
				else report_mismatch(names[line], "req_ready_o", 64'(exp_ready),
					64'(req_ready_o));
			if (acc_count - rsp_count == NUM_TIDS) saw_full = 1'b1;
			assert (mem_req_valid_o == (acc && !req_i.hit))
				else report_problem("memory request strobe does not match a miss accept");
			if (mem_req_valid_o && req_seen < n_misses) begin
				line = miss_line[req_seen];
				assert (mem_req_o.addr == addrs[line])
					else report_mismatch(names[line], "mem_req addr", 64'(addrs[line]),
						64'(mem_req_o.addr));
				assert (mem_req_o.id == MEM_ID_WIDTH'(line))
					else report_mismatch(names[line], "mem_req id", 64'(MEM_ID_WIDTH'(line)),
						64'(mem_req_o.id));
				req_cycle[req_seen] = cycle;
				req_seen++;
			end
			if (fill_valid_o) begin
				assert (!mem_rsp_ready_o)
					else report_problem("memory response port open while a fill is pending");
			end
			if (fill_valid_o && fill_ready_i && hit_wr) collisions++;
			if (fill_valid_o && fill_ready_i && !hit_wr) begin
				if (fill_count < n_misses) begin
					line = miss_line[fill_count];
					assert (fill_o.addr == addrs[line])
						else report_mismatch(names[line], "fill addr", 64'(addrs[line]),
							64'(fill_o.addr));
					assert (fill_o.data == datas[line])
						else report_mismatch(names[line], "fill data", datas[line], fill_o.data);
					fill_count++;
				end else begin
					report_problem("fill completed with no miss outstanding");
				end
			end
			if (rsp_valid_o && rsp_ready_i) begin
				if (rsp_count < n_tests) begin
					assert (rsp_o.tid == TID_WIDTH'(rsp_count))
						else report_mismatch(names[rsp_count], "rsp tid",
							64'(TID_WIDTH'(rsp_count)), 64'(rsp_o.tid));
					assert (rsp_o.data == datas[rsp_count])
						else report_mismatch(names[rsp_count], "rsp data", datas[rsp_count],
							rsp_o.data);
					rsp_count++;
				end else begin
					report_problem("core response with no request pending");
				end
			end
			if (mem_rsp_valid_i && mem_rsp_ready_o) mem_taken++;
			if (acc) begin
				acc_count++;
				if (!req_i.hit) miss_acc++;
			end
		end
	end

	initial begin
		while (!loaded) @(posedge clk);
		repeat (limit) @(posedge clk);
		report_problem("timeout, the run did not finish in time");
		print_counts();
		$display("test failed");
		$finish;
	end

	initial begin
		rst_n           = 1'b0;
		req_valid_i     = 1'b0;
		req_i           = '0;
		mem_rsp_valid_i = 1'b0;
		mem_rsp_i       = '0;
		fill_ready_i    = 1'b0;
		rsp_ready_i     = 1'b0;
		read_tests();
		limit  = n_tests * (max_delay + 40);
		loaded = 1'b1;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		assert (!fill_valid_o) else report_mismatch("reset", "fill_valid_o", 0, 64'(fill_valid_o));
		assert (!rsp_valid_o) else report_mismatch("reset", "rsp_valid_o", 0, 64'(rsp_valid_o));
		assert (!mem_req_valid_o)
			else report_mismatch("reset", "mem_req_valid_o", 0, 64'(mem_req_valid_o));
		assert (req_ready_o) else report_mismatch("reset", "req_ready_o", 1, 64'(req_ready_o));
		running = 1'b1;
		@(posedge clk);
		#2;
		drive_requests();
		while (rsp_count < n_tests || fill_count < n_misses) @(posedge clk);
		repeat (4) @(posedge clk);
		assert (collisions > 0)
			else report_problem("no hit write ever met a fill that was ready to complete");
		print_counts();
		if (value_errors + other_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

/* verif/miss_path_tests.txt */
# columns: test name, hit flag (1 hit, 0 miss), address (hex), data (hex), memory delay (cycles)
# data is the hit data for a hit and the memory response data for a miss
hit_run        1 00001000 1111000000000001 0
hit_run        1 00001040 1111000000000002 0
hit_run        1 00001080 1111000000000003 0
miss_then_hits 0 20000000 a5a5000000000004 6
miss_then_hits 1 000010c0 1111000000000005 0
miss_then_hits 1 00001100 1111000000000006 0
miss_order     0 20000040 a5a5000000000007 3
miss_order     0 20000080 a5a5000000000008 0
miss_order     0 200000c0 a5a5000000000009 9
hit_on_fill    0 20000100 a5a500000000000a 1
hit_on_fill    1 00001140 111100000000000b 0
hit_on_fill    1 00001180 111100000000000c 0
hit_on_fill    0 20000140 a5a500000000000d 2
hit_on_fill    1 000011c0 111100000000000e 0
tid_full       1 00001200 111100000000000f 0
tid_full       0 20000180 a5a5000000000010 4
tid_full       1 00001240 1111000000000011 0
tid_full       0 200001c0 a5a5000000000012 0
tid_full       1 00001280 1111000000000013 0
tid_wrap       0 20000200 a5a5000000000014 7
tid_wrap       1 000012c0 1111000000000015 0
tid_wrap       0 20000240 a5a5000000000016 2
tid_wrap       1 00001300 1111000000000017 0

/* vlog.f */
src/mem_bus_pkg.sv
src/miss_track_pkg.sv
src/tid_counter.sv
src/miss_fifo.sv
src/read_miss_handler.sv
src/reorder_buffer.sv
src/miss_path_top.sv
verif/miss_path_tb.sv

/* Makefile */
# Verilator flow for the read-miss return path.
VERILATOR ?= verilator
TOP       ?= miss_path_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
JOBS      ?= 4
PASS_MSG  := test passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -f $(FILELIST)

# status follows the pass line in the simulator output.
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
